// File: source/noc_pkg.sv
package noc_pkg;

  localparam int NUM_PORTS = 5;
  localparam int COORD_W   = 4;

  // port order doubles as the rotating priority order.
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_W = 3'd2,
    PORT_S = 3'd3,
    PORT_L = 3'd4
  } port_e;

  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'd0,
    FLIT_BODY   = 2'd1,
    FLIT_TAIL   = 2'd2,
    FLIT_SINGLE = 2'd3  // head and tail at once.
  } flit_kind_e;

  // head flits carry dest x in data[7:4], dest y in data[3:0].
  typedef struct packed {
    flit_kind_e  kind;
    logic [15:0] data;
  } flit_t;

  typedef struct packed {
    logic  rts;
    flit_t flit;
  } link_fwd_t;

  typedef logic [NUM_PORTS-1:0] port_vec_t;

  function automatic logic flit_is_head(flit_t f);
    return (f.kind == FLIT_HEAD) || (f.kind == FLIT_SINGLE);
  endfunction

  function automatic logic flit_is_tail(flit_t f);
    return (f.kind == FLIT_TAIL) || (f.kind == FLIT_SINGLE);
  endfunction

  function automatic logic [COORD_W-1:0] flit_dest_x(flit_t f);
    return f.data[7:4];
  endfunction

  function automatic logic [COORD_W-1:0] flit_dest_y(flit_t f);
    return f.data[3:0];
  endfunction

endpackage

// File: source/flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo import noc_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  link_fwd_t rx,
  output logic      rx_dcts,
  output flit_t     head,
  output logic      head_valid,
  input  port_vec_t grant
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             dcts_q;
  logic             push;
  logic             pop;
  logic             space;

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign rx_dcts    = dcts_q;

  assign push  = dcts_q;             // the dcts cycle is the transfer.
  assign pop   = head_valid && (|grant);
  assign space = (count < CNT_W'(DEPTH)) || pop;

  // one dcts pulse per flit; rts is low again after a transfer.
  always_ff @(posedge clk) begin
    if (rst) begin
      dcts_q <= 1'b0;
    end else begin
      dcts_q <= rx.rts && !dcts_q && space;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx.flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/route_calc.sv
`timescale 1ns/100ps

module route_calc import noc_pkg::*; #(
  parameter logic [COORD_W-1:0] CUR_X = '0,
  parameter logic [COORD_W-1:0] CUR_Y = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  flit_t     head,
  input  logic      head_valid,
  input  port_vec_t grant,
  output port_vec_t req
);

  port_vec_t          route_q;    // held route is zero between packets.
  port_vec_t          route_xy;
  port_vec_t          route_now;
  logic [COORD_W-1:0] dst_x;
  logic [COORD_W-1:0] dst_y;
  logic               granted;

  assign dst_x = flit_dest_x(head);
  assign dst_y = flit_dest_y(head);

  // x first, then y.
  always_comb begin
    route_xy = '0;
    if (dst_x > CUR_X) begin
      route_xy[PORT_E] = 1'b1;
    end else if (dst_x < CUR_X) begin
      route_xy[PORT_W] = 1'b1;
    end else if (dst_y > CUR_Y) begin
      route_xy[PORT_S] = 1'b1;
    end else if (dst_y < CUR_Y) begin
      route_xy[PORT_N] = 1'b1;
    end else begin
      route_xy[PORT_L] = 1'b1;
    end
  end

  always_comb begin
    if (route_q != '0) begin
      route_now = route_q;
    end else if (flit_is_head(head)) begin
      route_now = route_xy;
    end else begin
      route_now = '0;  // a stray body flit gets no route.
    end
  end

  assign req     = head_valid ? route_now : '0;
  assign granted = head_valid && (|grant);

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= '0;
    end else if (granted) begin
      route_q <= flit_is_tail(head) ? port_vec_t'('0) : route_now;
    end
  end

endmodule

// File: source/port_arbiter.sv
`timescale 1ns/100ps

module port_arbiter import noc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_vec_t req,
  input  flit_t     heads [NUM_PORTS],
  output port_vec_t grant,
  output link_fwd_t tx,
  input  logic      tx_dcts
);

  port_vec_t state;       // one-hot owner input that is zero when idle.
  port_vec_t next_state;
  port_e     owner;
  flit_t     sel_flit;
  logic      busy;
  logic      owner_req;
  logic      rts_q;
  logic      rts_d;
  logic      xfer;
  logic      tail_done;

  // first requester at or after start in cyclic port order.
  function automatic port_vec_t pick_from(port_vec_t r, port_e start);
    port_vec_t win;
    int        idx;
    win = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (int'(start) + k) % NUM_PORTS;
      if (r[idx] && (win == '0)) begin
        win[idx] = 1'b1;
      end
    end
    return win;
  endfunction

  assign busy      = (state != '0);
  assign owner_req = |(req & state);
  assign xfer      = rts_q && tx_dcts;
  assign tail_done = xfer && flit_is_tail(sel_flit);

  // crossbar select and owner index from the one-hot state.
  always_comb begin
    owner    = PORT_N;
    sel_flit = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (state[i]) begin
        owner    = port_e'(i);
        sel_flit = heads[i];
      end
    end
  end

  // the owner is kept for the whole packet and released on its tail.
  always_comb begin
    next_state = state;
    if (!busy) begin
      next_state = pick_from(req, PORT_N);
    end else if (tail_done) begin
      case (owner)
        PORT_N:  next_state = pick_from(req & ~state, PORT_E);
        PORT_E:  next_state = pick_from(req & ~state, PORT_W);
        PORT_W:  next_state = pick_from(req & ~state, PORT_S);
        PORT_S:  next_state = pick_from(req & ~state, PORT_L);
        default: next_state = pick_from(req & ~state, PORT_N);
      endcase
    end
  end

  // rts waits for a flit from the owner and drops right after dcts.
  always_comb begin
    if (xfer) begin
      rts_d = 1'b0;
    end else begin
      rts_d = owner_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= '0;
      rts_q <= 1'b0;
    end else begin
      state <= next_state;
      rts_q <= rts_d;
    end
  end

  assign grant   = state & {NUM_PORTS{xfer}};
  assign tx.rts  = rts_q;
  assign tx.flit = sel_flit;

endmodule

// File: source/noc_router.sv
`timescale 1ns/100ps

module noc_router import noc_pkg::*; #(
  parameter logic [COORD_W-1:0] CUR_X = '0,
  parameter logic [COORD_W-1:0] CUR_Y = '0,
  parameter int unsigned        DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  link_fwd_t rx [NUM_PORTS],
  output port_vec_t rx_dcts,
  output link_fwd_t tx [NUM_PORTS],
  input  port_vec_t tx_dcts
);

  flit_t     heads     [NUM_PORTS];
  port_vec_t head_valid;
  port_vec_t in_req    [NUM_PORTS];  // indexed by input with bit j asking output j.
  port_vec_t in_grant  [NUM_PORTS];
  port_vec_t out_req   [NUM_PORTS];  // indexed by output with bit i from input i.
  port_vec_t out_grant [NUM_PORTS];

  // crossbar wiring swaps input and output indices.
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_out
      assign out_req[j][i]  = in_req[i][j];
      assign in_grant[i][j] = out_grant[j][i];
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

    flit_fifo #(
      .DEPTH (DEPTH)
    ) u_fifo (
      .clk        (clk),
      .rst        (rst),
      .rx         (rx[p]),
      .rx_dcts    (rx_dcts[p]),
      .head       (heads[p]),
      .head_valid (head_valid[p]),
      .grant      (in_grant[p])
    );

    route_calc #(
      .CUR_X (CUR_X),
      .CUR_Y (CUR_Y)
    ) u_route (
      .clk        (clk),
      .rst        (rst),
      .head       (heads[p]),
      .head_valid (head_valid[p]),
      .grant      (in_grant[p]),
      .req        (in_req[p])
    );

    // every output sees all five heads.
    port_arbiter u_arb (
      .clk     (clk),
      .rst     (rst),
      .req     (out_req[p]),
      .heads   (heads),
      .grant   (out_grant[p]),
      .tx      (tx[p]),
      .tx_dcts (tx_dcts[p])
    );

  end

endmodule

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  localparam logic [COORD_W-1:0] ROUTER_X = 4'd2;
  localparam logic [COORD_W-1:0] ROUTER_Y = 4'd2;

  // expected flit and the link it must leave on.
  typedef struct packed {
    port_e port;
    flit_t flit;
  } exp_t;

  flit_t send_q [NUM_PORTS][$];  // flits waiting at each upstream sender.
  exp_t  exp_q  [NUM_PORTS][$];  // per source in send order.
  int    seq_no [NUM_PORTS];
  int    sent_flits;

  // x is resolved before y.
  function automatic port_e expected_port(logic [COORD_W-1:0] dx, logic [COORD_W-1:0] dy);
    if (dx > ROUTER_X) begin
      return PORT_E;
    end
    if (dx < ROUTER_X) begin
      return PORT_W;
    end
    if (dy > ROUTER_Y) begin
      return PORT_S;
    end
    if (dy < ROUTER_Y) begin
      return PORT_N;
    end
    return PORT_L;
  endfunction

  // upper byte is source port and sequence number.
  function automatic flit_t make_flit(flit_kind_e kind, int src, int seq, logic [7:0] low);
    flit_t f;
    f.kind = kind;
    f.data = {3'(src), 5'(seq), low};
    return f;
  endfunction

  task automatic queue_packet(int src, logic [COORD_W-1:0] dx, logic [COORD_W-1:0] dy, int len);
    flit_t      f;
    exp_t       e;
    flit_kind_e kind;
    logic [7:0] low;
    for (int k = 0; k < len; k++) begin
      if (len == 1) begin
        kind = FLIT_SINGLE;
      end else if (k == 0) begin
        kind = FLIT_HEAD;
      end else if (k == len - 1) begin
        kind = FLIT_TAIL;
      end else begin
        kind = FLIT_BODY;
      end
      low         = (k == 0) ? {dx, dy} : 8'($random(seed));
      f           = make_flit(kind, src, seq_no[src], low);
      seq_no[src] = (seq_no[src] + 1) % 32;
      e.port      = expected_port(dx, dy);
      e.flit      = f;
      send_q[src].push_back(f);
      exp_q[src].push_back(e);
      sent_flits++;
    end
  endtask

`endif

// File: testbench/tb_router.sv
`timescale 1ns/100ps

module tb_router import noc_pkg::*; ();

  logic      clk;
  logic      rst;
  link_fwd_t rx [NUM_PORTS];
  port_vec_t rx_dcts;
  link_fwd_t tx [NUM_PORTS];
  port_vec_t tx_dcts;

  int    seed = 32'h5a26;
  int    errors;
  int    checks;
  int    cycles;
  int    rcv_flits;
  int    rcv_port  [NUM_PORTS];
  int    open_src  [NUM_PORTS];  // source of the packet in flight on each link.
  int    delay     [NUM_PORTS];
  int    hold_cnt  [NUM_PORTS];
  bit    hold_on   [NUM_PORTS];
  flit_t hold_flit [NUM_PORTS];
  int    local_order [$];

  `include "tb_model.svh"

  localparam logic [COORD_W-1:0] DEST_X [NUM_PORTS] = '{4'd3, 4'd1, 4'd2, 4'd2, 4'd2};
  localparam logic [COORD_W-1:0] DEST_Y [NUM_PORTS] = '{4'd2, 4'd2, 4'd1, 4'd3, 4'd2};

  noc_router #(
    .CUR_X (ROUTER_X),
    .CUR_Y (ROUTER_Y),
    .DEPTH (4)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .rx      (rx),
    .rx_dcts (rx_dcts),
    .tx      (tx),
    .tx_dcts (tx_dcts)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic verify(bit ok, string msg);
    checks++;
    assert (ok) else begin
      $display("FAILED at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  function automatic bit links_quiet();
    bit quiet;
    quiet = (rx_dcts == '0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (tx[p].rts) begin
        quiet = 1'b0;
      end
    end
    return quiet;
  endfunction

  task automatic take_flit(int p, flit_t f);
    int   src;
    bit   pending;
    exp_t e;
    src     = int'(f.data[15:13]);
    pending = 1'b0;
    if (src < NUM_PORTS) begin
      pending = (exp_q[src].size() != 0);
    end
    rcv_flits++;
    rcv_port[p]++;
    assert (pending) else begin
      $display("port %0d delivered flit %h that no input had pending", p, f);
      errors++;
    end
    if (pending) begin
      e = exp_q[src].pop_front();
      verify(e.flit == f, $sformatf("port %0d got flit %h, expected %h", p, f, e.flit));
      verify(e.port == port_e'(p), $sformatf("flit %h left on port %0d, not %0d", f, p, e.port));
    end
    if (f.kind == FLIT_HEAD || f.kind == FLIT_SINGLE) begin
      assert (open_src[p] < 0) else begin
        $display("port %0d started a packet from input %0d inside one from input %0d",
                 p, src, open_src[p]);
        errors++;
      end
      if (p == PORT_L) begin
        local_order.push_back(src);
      end
      open_src[p] = (f.kind == FLIT_HEAD) ? src : -1;
    end else begin
      assert (open_src[p] == src) else begin
        $display("port %0d mixed a flit from input %0d into a packet from input %0d",
                 p, src, open_src[p]);
        errors++;
      end
      if (f.kind == FLIT_TAIL) begin
        open_src[p] = -1;
      end
    end
  endtask

  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (send_q[p].size() != 0 || exp_q[p].size() != 0 || rx[p].rts || tx[p].rts) begin
          busy = 1'b1;
        end
      end
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic report_test(string name, int errs0);
    if (errors == errs0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs0);
    end
  endtask

  // upstream senders move one flit per rts/dcts transfer.
  always @(posedge clk) begin
    flit_t nf;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rst) begin
        rx[p].rts <= 1'b0;
      end else begin
        verify(rx[p].rts || !rx_dcts[p], $sformatf("input %0d raised dcts without rts", p));
        if (rx[p].rts) begin
          if (rx_dcts[p]) begin
            rx[p].rts <= 1'b0;
          end
        end else if (send_q[p].size() != 0) begin
          nf = send_q[p].pop_front();
          rx[p].flit <= nf;
          rx[p].rts  <= 1'b1;
        end
      end
    end
  end

  // downstream receivers with a random accept delay and an optional stall.
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rst) begin
        tx_dcts[p] <= 1'b0;
      end else if (tx_dcts[p]) begin
        tx_dcts[p] <= 1'b0;  // one-cycle pulse.
        delay[p] = $unsigned($random(seed)) % 4;
      end else if (hold_cnt[p] > 0 && (tx[p].rts || hold_on[p])) begin
        if (!hold_on[p]) begin
          hold_on[p]   = 1'b1;
          hold_flit[p] = tx[p].flit;
        end
        verify(tx[p].rts && tx[p].flit == hold_flit[p],
               $sformatf("port %0d changed its link during a stall", p));
        hold_cnt[p]--;
        hold_on[p] = (hold_cnt[p] != 0);
      end else if (tx[p].rts) begin
        if (delay[p] == 0) begin
          tx_dcts[p] <= 1'b1;
        end else begin
          delay[p]--;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (tx[p].rts && tx_dcts[p]) begin
          take_flit(p, tx[p].flit);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 40 * sent_flits + 200) begin
      $display("timeout after %0d cycles with packets still in flight", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int         errs0;
    int         sent0;
    int         rcv0;
    int         base;
    int         len;
    logic [3:0] rnd_x;
    logic [3:0] rnd_y;
    int         want [NUM_PORTS];
    rst     <= 1'b1;
    tx_dcts <= '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rx[p]       <= '0;
      open_src[p] = -1;
      delay[p]    = 0;
      hold_cnt[p] = 0;
      hold_on[p]  = 1'b0;
      rcv_port[p] = 0;
      seq_no[p]   = 0;
    end

    errs0 = errors;
    for (int k = 0; k < 9; k++) begin
      @(posedge clk);
      if (k == 7) begin
        rst <= 1'b0;  // eight edges with reset high.
      end
      @(negedge clk);
      verify(links_quiet(), $sformatf("link active in reset cycle %0d", k));
    end
    report_test("reset", errs0);

    errs0 = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      want[p] = rcv_port[p];
    end
    @(negedge clk);
    for (int d = 0; d < NUM_PORTS; d++) begin
      queue_packet(PORT_L, DEST_X[d], DEST_Y[d], 1);
      queue_packet(PORT_L, DEST_X[d], DEST_Y[d], 3);
      want[expected_port(DEST_X[d], DEST_Y[d])] += 4;
    end
    wait_drain();
    for (int p = 0; p < NUM_PORTS; p++) begin
      verify(rcv_port[p] == want[p], $sformatf("port %0d carried %0d flits", p, rcv_port[p]));
    end
    report_test("routing", errs0);

    errs0 = errors;
    base  = rcv_port[PORT_E];
    @(negedge clk);
    queue_packet(PORT_W, 4'd3, 4'd2, 4);
    queue_packet(PORT_N, 4'd3, 4'd2, 4);
    wait_drain();
    verify(rcv_port[PORT_E] == base + 8, "east link did not carry both packets");
    report_test("wormhole", errs0);

    errs0 = errors;
    base  = rcv_port[PORT_E];
    @(negedge clk);
    queue_packet(PORT_L, 4'd4, 4'd2, 6);
    while (rcv_port[PORT_E] < base + 2) begin
      @(negedge clk);
    end
    hold_cnt[PORT_E] = 10;  // stall in the middle of the packet.
    wait_drain();
    verify(hold_cnt[PORT_E] == 0, "east stall never took effect");
    verify(rcv_port[PORT_E] == base + 6, "east link lost or repeated a flit");
    report_test("backpressure", errs0);

    errs0 = errors;
    local_order.delete();
    @(negedge clk);
    for (int n = 0; n < 3; n++) begin
      for (int p = PORT_N; p <= PORT_S; p++) begin
        queue_packet(p, ROUTER_X, ROUTER_Y, 1);
      end
    end
    wait_drain();
    verify(local_order.size() == 12, "local link did not carry twelve packets");
    for (int k = 0; k < local_order.size() && k < 12; k++) begin
      verify(local_order[k] == k % 4,
             $sformatf("local packet %0d came from input %0d", k, local_order[k]));
    end
    report_test("fairness", errs0);

    errs0 = errors;
    sent0 = sent_flits;
    rcv0  = rcv_flits;
    @(negedge clk);
    for (int n = 0; n < 6; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        rnd_x = 4'($unsigned($random(seed)) % 5);
        rnd_y = 4'($unsigned($random(seed)) % 5);
        len   = 1 + $unsigned($random(seed)) % 4;
        queue_packet(p, rnd_x, rnd_y, len);
      end
    end
    wait_drain();
    verify(rcv_flits - rcv0 == sent_flits - sent0, "random traffic flit count differs");
    report_test("random", errs0);

    $display("tests 6, flits sent %0d, received %0d, checks %0d, errors %0d",
             sent_flits, rcv_flits, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+testbench
source/noc_pkg.sv
source/flit_fifo.sv
source/route_calc.sv
source/port_arbiter.sv
source/noc_router.sv
testbench/tb_router.sv

// File: run.sh
#!/bin/sh
# build the router testbench with verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_router \
  -f list.f -o tb_router > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_router > sim.log 2>&1
cat sim.log
grep -q "^Result: PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
